// ==== hw/aib_rxfifo_params.svh ====
// ########################################
// RX FIFO sizing macros: depth, pointer,
// segment width and consumer credits
// ########################################
`ifndef AIB_RXFIFO_PARAMS_SVH
`define AIB_RXFIFO_PARAMS_SVH

// Rows of the storage array
`define RXF_FF_DEPTH 4

// Entry slots per row is fixed at four
`define RXF_DEPTH4 (4 * `RXF_FF_DEPTH)

// Entry index width, wrap bit not included
`define RXF_PNT_S ($clog2(`RXF_DEPTH4))

// One storage segment, also the GEN1 word width
`define RXF_SEG_W 40

// Credits granted by the consumer out of reset
`define RXF_CREDITS 4

`endif

// ==== hw/aib_rxfifo_pkg.sv ====
// ########################################
// RX FIFO types: entry union with GEN1 and
// GEN2 views, per-row segment enables
// ########################################
`include "aib_rxfifo_params.svh"

package aib_rxfifo_pkg;

  // GEN2 view, full 80-bit word in two halves
  typedef struct packed {
    logic [`RXF_SEG_W-1:0] hi;       // Bits 79-40
    logic [`RXF_SEG_W-1:0] lo;       // Bits 39-0
  } rxf_gen2_t;

  // GEN1 view, only the lower half is written
  typedef struct packed {
    logic [`RXF_SEG_W-1:0] unused;   // Stale, never written in GEN1
    logic [`RXF_SEG_W-1:0] data;     // 40-bit word
  } rxf_gen1_t;

  // One FIFO entry, decoded by mode
  typedef union packed {
    rxf_gen2_t gen2;
    rxf_gen1_t gen1;
  } rxf_entry_u;

  // Eight segment enables per row, one per 40-bit position
  typedef logic [`RXF_FF_DEPTH-1:0][7:0] rxf_seg_en_t;

endpackage

// ==== hw/aib_rxfifo_if.sv ====
// ########################################
// Write-path interface between pointer,
// decode and storage stages
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

interface rxf_wr_if
  import aib_rxfifo_pkg::*;
();

  logic                  wr_en;      // Stage 1 word valid
  logic [`RXF_PNT_S-1:0] wr_pnt;     // Entry slot of the word
  rxf_entry_u            wr_data;    // Stage 1 word

  rxf_seg_en_t           seg_en;     // Stage 2 registered write enables
  rxf_entry_u            seg_data;   // Stage 2 word

  // Pointer stage
  modport pnt_mp (
    output wr_en,
    output wr_pnt,
    output wr_data
  );

  // Enable decode stage
  modport gate_mp (
    input  wr_en,
    input  wr_pnt,
    input  wr_data,
    output seg_en,
    output seg_data
  );

  // Storage array
  modport mem_mp (
    input  seg_en,
    input  seg_data
  );

endinterface

// ==== hw/aib_rxfifo_wr_pnt.sv ====
// ########################################
// Stage 1: input register, write pointer,
// full detect and sticky overflow
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_wr_pnt
  import aib_rxfifo_pkg::*;
(
  input  logic                rxf_wr_clk,  // RX FIFO write clock
  input  logic                rst_n,
  input  logic                rx_valid,    // Word from link, no back-pressure
  input  logic [2*`RXF_SEG_W-1:0] rx_data,
  input  logic [`RXF_PNT_S:0] rd_pnt,      // Read pointer with wrap bit
  output logic                overflow,    // Sticky until reset
  rxf_wr_if.pnt_mp            wr
);

  logic [`RXF_PNT_S:0] wptr;     // Next free slot, wrap bit on top
  logic                full;
  logic                accept;

  // Counts words still in flight to the array
  assign full = (wptr[`RXF_PNT_S] != rd_pnt[`RXF_PNT_S]) &&
                (wptr[`RXF_PNT_S-1:0] == rd_pnt[`RXF_PNT_S-1:0]);

  assign accept = rx_valid & ~full;  // Drop on full

  always_ff @(posedge rxf_wr_clk)
  begin
    if (!rst_n)
    begin
      wptr      <= '0;
      wr.wr_en  <= 1'b0;
      wr.wr_pnt <= '0;
      overflow  <= 1'b0;
    end
    else
    begin
      wr.wr_en <= accept;
      if (accept)
      begin
        wr.wr_pnt <= wptr[`RXF_PNT_S-1:0];  // Slot for this word
        wptr      <= wptr + 1'b1;
      end
      if (rx_valid && full)
        overflow <= 1'b1;                   // Word lost
    end
  end

  // Word register, payload only
  always_ff @(posedge rxf_wr_clk)
  begin
    if (accept)
      wr.wr_data <= rxf_entry_u'(rx_data);
  end

endmodule

// ==== hw/aib_rxfifo_clk_gating.sv ====
// ########################################
// Stage 2: pointer and mode decode into
// registered per-segment write enables
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_clk_gating
  import aib_rxfifo_pkg::*;
(
  input  logic      rxf_wr_clk,   // RX FIFO write clock
  input  logic      rst_n,
  input  logic      m_gen2_mode,  // Static, GEN2 uses both halves
  rxf_wr_if.gate_mp wr
);

  // Slot inside a row
  localparam logic [1:0] WD_79_0    = 2'd0;
  localparam logic [1:0] WD_159_80  = 2'd1;
  localparam logic [1:0] WD_239_160 = 2'd2;
  localparam logic [1:0] WD_319_240 = 2'd3;

  logic [`RXF_PNT_S-3:0] row;       // Upper pointer bits
  logic [1:0]            slot;      // Lower pointer bits
  logic [2:0]            lo_seg;    // Segment of bits 39-0 of the word
  logic [2:0]            hi_seg;    // Segment of bits 79-40
  rxf_seg_en_t           seg_en_d;

  assign row    = wr.wr_pnt[`RXF_PNT_S-1:2];
  assign slot   = wr.wr_pnt[1:0];
  assign hi_seg = {lo_seg[2:1], 1'b1};

  always_comb
  begin
    case (slot)
      WD_79_0:    lo_seg = 3'd0;  // Segments 39-0 and 79-40
      WD_159_80:  lo_seg = 3'd2;  // Segments 119-80 and 159-120
      WD_239_160: lo_seg = 3'd4;  // Segments 199-160 and 239-200
      WD_319_240: lo_seg = 3'd6;  // Segments 279-240 and 319-280
      default:    lo_seg = 3'd0;
    endcase
  end

  // One-hot enables, pair in GEN2, lower only in GEN1
  always_comb
  begin
    seg_en_d               = '0;
    seg_en_d[row][lo_seg]  = wr.wr_en;
    seg_en_d[row][hi_seg]  = wr.wr_en & m_gen2_mode;
  end

  // Stand-in for the clock gate cells
  always_ff @(posedge rxf_wr_clk)
  begin
    if (!rst_n)
      wr.seg_en <= '0;              // No segment written
    else
      wr.seg_en <= seg_en_d;
  end

  // Data follows the enables by the same stage
  always_ff @(posedge rxf_wr_clk)
  begin
    if (wr.wr_en)
      wr.seg_data <= wr.wr_data;
  end

endmodule

// ==== hw/aib_rxfifo_mem.sv ====
// ########################################
// Stage 3: segmented storage array with
// asynchronous read port
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_mem
  import aib_rxfifo_pkg::*;
(
  input  logic                  rxf_wr_clk,  // RX FIFO write clock
  rxf_wr_if.mem_mp              wr,
  input  logic [`RXF_PNT_S-1:0] rd_pnt,      // Entry to read
  output rxf_entry_u            rd_entry
);

  // Rows of eight 40-bit segments, four entries per row
  logic [`RXF_SEG_W-1:0] seg_q [`RXF_FF_DEPTH][8];

  logic [`RXF_PNT_S-3:0] rd_row;
  logic [1:0]            rd_slot;

  // Each segment loads only under its own enable
  for (genvar r = 0; r < `RXF_FF_DEPTH; r++)
  begin : g_row
    for (genvar s = 0; s < 8; s++)
    begin : g_seg
      if (s % 2 == 1)
      begin : g_hi
        always_ff @(posedge rxf_wr_clk)
        begin
          if (wr.seg_en[r][s])
            seg_q[r][s] <= wr.seg_data.gen2.hi;  // Upper half
        end
      end
      else
      begin : g_lo
        always_ff @(posedge rxf_wr_clk)
        begin
          if (wr.seg_en[r][s])
            seg_q[r][s] <= wr.seg_data.gen2.lo;  // Lower half, GEN1 word
        end
      end
    end
  end

  assign rd_row  = rd_pnt[`RXF_PNT_S-1:2];
  assign rd_slot = rd_pnt[1:0];

  // Upper half stays stale in GEN1
  always_comb
  begin
    rd_entry.gen2.hi = seg_q[rd_row][{rd_slot, 1'b1}];
    rd_entry.gen2.lo = seg_q[rd_row][{rd_slot, 1'b0}];
  end

endmodule

// ==== hw/aib_rxfifo_rd.sv ====
// ########################################
// Stage 4: read pointer, credit counter
// and registered output word
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_rd
  import aib_rxfifo_pkg::*;
(
  input  logic                    rxf_wr_clk,     // Read side shares write clock
  input  logic                    rst_n,
  input  logic                    m_gen2_mode,    // Selects entry view
  input  logic                    credit_return,  // One credit back per cycle
  input  logic [`RXF_PNT_S:0]     wr_pnt_vis,     // Committed write pointer
  input  rxf_entry_u              rd_entry,       // Entry at rd_pnt
  output logic [`RXF_PNT_S:0]     rd_pnt,
  output logic                    out_valid,
  output logic [2*`RXF_SEG_W-1:0] out_data
);

  localparam int CRD_W = $clog2(`RXF_CREDITS + 1);

  logic [CRD_W-1:0]          credits;   // Credits held right now
  logic                      empty;
  logic                      fire;      // Issue a word this edge
  logic [2*`RXF_SEG_W-1:0]   dec_word;

  assign empty = (rd_pnt == wr_pnt_vis);     // Wrap bit included
  assign fire  = (credits != '0) && !empty;

  // Union view by mode
  always_comb
  begin
    if (m_gen2_mode)
      dec_word = {rd_entry.gen2.hi, rd_entry.gen2.lo};
    else
      dec_word = {{`RXF_SEG_W{1'b0}}, rd_entry.gen1.data};  // Drop stale half
  end

  always_ff @(posedge rxf_wr_clk)
  begin
    if (!rst_n)
    begin
      credits   <= CRD_W'(`RXF_CREDITS);  // Initial grant
      rd_pnt    <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= fire;
      if (fire)
        rd_pnt <= rd_pnt + 1'b1;
      // Spend on issue, refill on return
      credits <= credits - CRD_W'(fire) + CRD_W'(credit_return);
    end
  end

  // Output word register
  always_ff @(posedge rxf_wr_clk)
  begin
    if (fire)
      out_data <= dec_word;
  end

endmodule

// ==== hw/aib_rxfifo_top.sv ====
// ########################################
// RX FIFO top: four pipeline stages and
// the committed write pointer
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_top
  import aib_rxfifo_pkg::*;
(
  input  logic                    rxf_wr_clk,     // RX FIFO write clock
  input  logic                    rst_n,
  input  logic                    m_gen2_mode,    // Static, change only in reset
  input  logic                    rx_valid,
  input  logic [2*`RXF_SEG_W-1:0] rx_data,        // GEN1 uses bits 39-0
  input  logic                    credit_return,
  output logic                    out_valid,
  output logic [2*`RXF_SEG_W-1:0] out_data,
  output logic                    overflow
);

  rxf_wr_if wr_if ();

  logic [`RXF_PNT_S:0] rd_pnt;
  logic [`RXF_PNT_S:0] wr_pnt_vis;   // Advances with each array write
  rxf_entry_u          rd_entry;

  // Any active enable means one entry lands this edge
  always_ff @(posedge rxf_wr_clk)
  begin
    if (!rst_n)
      wr_pnt_vis <= '0;
    else if (|wr_if.seg_en)
      wr_pnt_vis <= wr_pnt_vis + 1'b1;
  end

  aib_rxfifo_wr_pnt u_wr_pnt (
    .rxf_wr_clk (rxf_wr_clk),
    .rst_n      (rst_n),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .rd_pnt     (rd_pnt),
    .overflow   (overflow),
    .wr         (wr_if.pnt_mp)
  );

  aib_rxfifo_clk_gating u_clk_gating (
    .rxf_wr_clk  (rxf_wr_clk),
    .rst_n       (rst_n),
    .m_gen2_mode (m_gen2_mode),
    .wr          (wr_if.gate_mp)
  );

  aib_rxfifo_mem u_mem (
    .rxf_wr_clk (rxf_wr_clk),
    .wr         (wr_if.mem_mp),
    .rd_pnt     (rd_pnt[`RXF_PNT_S-1:0]),  // Wrap bit not needed here
    .rd_entry   (rd_entry)
  );

  aib_rxfifo_rd u_rd (
    .rxf_wr_clk    (rxf_wr_clk),
    .rst_n         (rst_n),
    .m_gen2_mode   (m_gen2_mode),
    .credit_return (credit_return),
    .wr_pnt_vis    (wr_pnt_vis),
    .rd_entry      (rd_entry),
    .rd_pnt        (rd_pnt),
    .out_valid     (out_valid),
    .out_data      (out_data)
  );

endmodule

// ==== tests/aib_rxfifo_assert.sv ====
// ########################################
// Port-level checker for the RX FIFO:
// credit limit, sticky overflow, reset
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_assert (
  input logic rxf_wr_clk,
  input logic rst_n,
  input logic credit_return,
  input logic out_valid,
  input logic overflow
);

  int   crd_cnt;              // Credits seen at the ports
  logic ret_q;                // Return of the last edge, not yet spent
  logic rst_q;                // rst_n one edge back
  logic crd_fail = 1'b0;
  logic ovf_fail = 1'b0;
  logic rst_fail = 1'b0;
  logic any_fail;             // Sampled by the testbench

  assign any_fail = crd_fail | ovf_fail | rst_fail;

  always_ff @(posedge rxf_wr_clk)
  begin
    if (!rst_n)
    begin
      crd_cnt <= `RXF_CREDITS;  // Grant out of reset
      ret_q   <= 1'b0;
    end
    else
    begin
      crd_cnt <= crd_cnt - int'(out_valid) + int'(credit_return);
      ret_q   <= credit_return;
    end
  end

  always_ff @(posedge rxf_wr_clk)
  begin
    rst_q <= rst_n;
  end

  // A word needs a credit held before its return is counted
  credit_limit: assert property (@(posedge rxf_wr_clk) disable iff (!rst_n)
    out_valid |-> (crd_cnt > int'(ret_q)))
    else
    begin
      crd_fail = 1'b1;
      $error("out_valid high while the consumer holds no credit");
    end

  // Sticky until reset
  overflow_sticky: assert property (@(posedge rxf_wr_clk) disable iff (!rst_n)
    $fell(overflow) |-> !rst_q)
    else
    begin
      ovf_fail = 1'b1;
      $error("overflow cleared without a reset");
    end

  // First cycle out of reset
  reset_state: assert property (@(posedge rxf_wr_clk)
    (rst_n && !rst_q) |-> (!out_valid && !overflow))
    else
    begin
      rst_fail = 1'b1;
      $error("out_valid or overflow high right after reset");
    end

endmodule

bind aib_rxfifo_top aib_rxfifo_assert u_assert (
  .rxf_wr_clk    (rxf_wr_clk),
  .rst_n         (rst_n),
  .credit_return (credit_return),
  .out_valid     (out_valid),
  .overflow      (overflow)
);

// ==== tests/aib_rxfifo_tb.sv ====
// ########################################
// RX FIFO testbench: stimulus, reference
// queue, credit consumer and timeout
// ########################################
`timescale 1ns/1ps
`include "aib_rxfifo_params.svh"

module aib_rxfifo_tb;

  localparam int W              = 2 * `RXF_SEG_W;
  localparam int TIMEOUT_CYCLES = 4000;  // About 130 words, five resets, slow random credit
  localparam int CRD_HOLD       = 0;     // Consumer keeps its credits
  localparam int CRD_RANDOM     = 1;
  localparam int CRD_ALL        = 2;     // Each used credit back in turn

  logic         clk           = 1'b0;
  logic         rst_n         = 1'b0;
  logic         m_gen2_mode   = 1'b0;
  logic         rx_valid      = 1'b0;
  logic [W-1:0] rx_data       = '0;
  logic         credit_return = 1'b0;
  logic         out_valid;
  logic [W-1:0] out_data;
  logic         overflow;

  logic [W-1:0] exp_q [$];        // Words the FIFO must deliver, in order
  int           acc_cnt      = 0; // Accepted since reset
  int           rd_cnt       = 0; // Delivered since reset
  int           out_cnt      = 0; // Delivered over the whole run
  int           owed         = 0; // Credits used and not yet returned
  int           cycle_cnt    = 0;
  logic         ovf_model    = 1'b0;
  int           crd_mode     = CRD_HOLD;
  int           release_req  = 0; // Single credits asked for in hold mode
  int           release_done = 0;
  int           base;

  aib_rxfifo_top aib_rxfifo_i (
    .rxf_wr_clk    (clk),
    .rst_n         (rst_n),
    .m_gen2_mode   (m_gen2_mode),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .overflow      (overflow)
  );

  initial
  begin
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  // Model, checks and consumer on the values the DUT samples
  always @(posedge clk)
  begin : monitor
    logic [W-1:0] exp_word;
    logic         give;
    cycle_cnt++;
    assert (cycle_cnt < TIMEOUT_CYCLES)
      else
      begin
        $display("Timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES);
        abort_run();
      end
    assert (!aib_rxfifo_i.u_assert.any_fail)
      else
      begin
        $display("A port assertion of the bound checker failed");
        abort_run();
      end
    if (!rst_n)
    begin
      exp_q.delete();
      acc_cnt       = 0;
      rd_cnt        = 0;
      owed          = 0;
      ovf_model     = 1'b0;
      release_done  = release_req;   // Stale requests die in reset
      credit_return <= 1'b0;
    end
    else
    begin
      assert (overflow === ovf_model)
        else
        begin
          $display("CHECK FAILED time=%0t signal=overflow expected=%b got=%b",
                   $time, ovf_model, overflow);
          abort_run();
        end
      if (out_valid)
      begin
        assert (exp_q.size() != 0)
          else
          begin
            $display("Word delivered with none expected at %0t", $time);
            abort_run();
          end
        exp_word = exp_q.pop_front();
        assert (out_data === exp_word)
          else
          begin
            $display("CHECK FAILED time=%0t signal=out_data expected=%h got=%h",
                     $time, exp_word, out_data);
            abort_run();
          end
        rd_cnt++;
        out_cnt++;
        owed++;
      end
      if (rx_valid)
      begin
        if (acc_cnt - rd_cnt < `RXF_DEPTH4)   // Entries held, in flight counted
        begin
          if (m_gen2_mode)
            exp_q.push_back(rx_data);
          else
            exp_q.push_back({{`RXF_SEG_W{1'b0}}, rx_data[`RXF_SEG_W-1:0]});  // Upper half zero
          acc_cnt++;
        end
        else
          ovf_model = 1'b1;                   // Dropped word
      end
      give = 1'b0;
      if (owed > 0)
      begin
        if (crd_mode == CRD_ALL)
          give = 1'b1;
        else if (crd_mode == CRD_RANDOM)
          give = ($urandom % 2) == 1;
        else if (release_done < release_req)
        begin
          give = 1'b1;
          release_done++;
        end
      end
      if (give)
        owed--;
      credit_return <= give;
    end
  end

  task automatic do_reset(input logic gen2);
    @(posedge clk);
    rst_n       <= 1'b0;
    rx_valid    <= 1'b0;
    m_gen2_mode <= gen2;             // Mode moves only in reset
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic send_words(input int n, input bit gaps);
    int sent;
    sent = 0;
    while (sent < n)
    begin
      @(posedge clk);
      if (gaps && ($urandom % 4) == 0)
        rx_valid <= 1'b0;            // Idle link cycle
      else
      begin
        rx_valid <= 1'b1;
        rx_data  <= {16'($urandom), $urandom, $urandom};
        sent++;
      end
    end
    @(posedge clk);
    rx_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    do @(posedge clk); while (exp_q.size() != 0);
  endtask

  task automatic wait_outs(input int target);
    while (out_cnt < target)
      @(posedge clk);
  endtask

  task automatic expect_outs(input int target);
    repeat (12) @(posedge clk);      // Time for any extra word to show
    assert (out_cnt == target)
      else
      begin
        $display("CHECK FAILED time=%0t signal=out_valid count expected=%0d got=%0d",
                 $time, target, out_cnt);
        abort_run();
      end
  endtask

  initial
  begin
    void'($urandom(32'h7094e76f));

    // GEN1 order, random credit
    do_reset(1'b0);
    crd_mode <= CRD_RANDOM;
    send_words(30, 1'b1);
    wait_drain();

    // GEN2 order, random credit
    do_reset(1'b1);
    send_words(30, 1'b1);
    wait_drain();

    // Credit limit, then one credit at a time
    crd_mode <= CRD_HOLD;
    do_reset(1'b0);
    base = out_cnt;
    send_words(8, 1'b0);
    wait_outs(base + `RXF_CREDITS);
    expect_outs(base + `RXF_CREDITS);
    release_req <= release_req + 1;
    wait_outs(base + `RXF_CREDITS + 1);
    expect_outs(base + `RXF_CREDITS + 1);
    crd_mode <= CRD_ALL;
    wait_drain();

    // Fill past 16 entries with no credit back
    crd_mode <= CRD_HOLD;
    do_reset(1'b1);
    send_words(24, 1'b0);
    crd_mode <= CRD_ALL;
    wait_drain();
    assert (overflow === 1'b1)
      else
      begin
        $display("CHECK FAILED time=%0t signal=overflow expected=1 got=%b",
                 $time, overflow);
        abort_run();
      end

    // Pointer wrap under steady credit
    do_reset(1'b1);
    send_words(40, 1'b0);
    wait_drain();
    assert (overflow === 1'b0)
      else
      begin
        $display("CHECK FAILED time=%0t signal=overflow expected=0 got=%b",
                 $time, overflow);
        abort_run();
      end

    @(posedge clk);
    if (aib_rxfifo_i.u_assert.any_fail)
    begin
      $display("A port assertion of the bound checker failed");
      abort_run();
    end
    else
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
+incdir+hw
hw/aib_rxfifo_pkg.sv
hw/aib_rxfifo_if.sv
hw/aib_rxfifo_wr_pnt.sv
hw/aib_rxfifo_clk_gating.sv
hw/aib_rxfifo_mem.sv
hw/aib_rxfifo_rd.sv
hw/aib_rxfifo_top.sv
tests/aib_rxfifo_assert.sv
tests/aib_rxfifo_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RX FIFO testbench with Verilator, pass only on the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module aib_rxfifo_tb \
  -o aib_rxfifo_sim > build.log 2>&1 ||
  { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/aib_rxfifo_sim +verilator+error+limit+10 > sim.log 2>&1
cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log &&
  { echo "Simulation passed"; exit 0; } ||
  { echo "Simulation failed, see sim.log"; exit 1; }
